/* src/fabric_pkg.sv */
//####################
// shared widths, register map and enums of the transfer fabric
// offsets are byte addresses on the 20-bit register bus
// per-channel registers sit at base + 4*n
//####################
package fabric_pkg;

  localparam int ADDR_W = 20;
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;
  localparam int LEN_W  = 7;  // up to 127 words per transfer

  localparam logic [ADDR_W-1:0] OFS_CFG      = 20'h00000;  // stride 4
  localparam logic [ADDR_W-1:0] OFS_RAM_MODE = 20'h00020;
  localparam logic [ADDR_W-1:0] OFS_STATUS   = 20'h00068;  // busy bits
  localparam logic [ADDR_W-1:0] OFS_RESULT   = 20'h00080;  // stride 4
  localparam logic [ADDR_W-1:0] OFS_LAUNCH   = 20'h00200;  // stride 4
  localparam logic [ADDR_W-1:0] OFS_ID       = 20'h00800;

  localparam logic [DATA_W-1:0] ID_WORD = 32'hCA11EF3A;

  // operand memory n answers where addr[19:12] == RAM_REGION_BASE + n
  localparam logic [7:0] RAM_REGION_BASE = 8'd1;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_WRITE,
    BUS_READ,
    BUS_READ_WAIT
  } bus_state_e;

  typedef enum logic [2:0] {
    CH_IDLE,
    CH_FETCH,  // memory read ahead of a TCDM write
    CH_REQ,
    CH_WAIT
  } chan_state_e;

  typedef enum logic [1:0] {
    MODE_WORD,
    MODE_HALF,
    MODE_BYTE,
    MODE_WORD_ALT  // same as word
  } ram_mode_e;

endpackage

/* src/lane_align.sv */
//####################
// lane steering between the bus and a word-wide operand memory
// narrow writes store the selected lane zero-extended
// narrow reads place the stored low lane back at the byte address
//####################
`timescale 1ns/1ps
module lane_align
  import fabric_pkg::*;
(
  input  logic [1:0]        addr_lo,
  input  ram_mode_e         wmode,
  input  ram_mode_e         rmode,
  input  logic [DATA_W-1:0] wdata_raw,
  input  logic [DATA_W-1:0] rdata_word,
  output logic [DATA_W-1:0] wdata_word,
  output logic [DATA_W-1:0] rdata_aligned
);

  always_comb begin
    case (wmode)
      MODE_HALF: begin
        if (addr_lo[1]) wdata_word = {16'b0, wdata_raw[31:16]};
        else wdata_word = {16'b0, wdata_raw[15:0]};
      end
      MODE_BYTE: wdata_word = {24'b0, wdata_raw[8*addr_lo +: 8]};
      default:   wdata_word = wdata_raw;  // word and alternate word
    endcase
  end

  // read side works on the registered memory word
  always_comb begin
    case (rmode)
      MODE_HALF: begin
        if (addr_lo[1]) rdata_aligned = {rdata_word[15:0], 16'b0};
        else rdata_aligned = {16'b0, rdata_word[15:0]};
      end
      MODE_BYTE: rdata_aligned = {24'b0, rdata_word[7:0]} << (8 * addr_lo);
      default:   rdata_aligned = rdata_word;
    endcase
  end

endmodule

/* src/operand_ram.sv */
//####################
// dual-port word memory, read data registered one cycle after index
// read returns the old word when the same port writes it
// no reset, contents are undefined until written
//####################
`timescale 1ns/1ps
module operand_ram
  import fabric_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic              CLK,
  input  logic [RAM_AW-1:0] a_idx,
  input  logic              a_we,
  input  logic [DATA_W-1:0] a_wdata,
  output logic [DATA_W-1:0] a_rdata,
  input  logic [RAM_AW-1:0] b_idx,
  input  logic              b_we,
  input  logic [DATA_W-1:0] b_wdata,
  output logic [DATA_W-1:0] b_rdata
);

  logic [DATA_W-1:0] mem [2**RAM_AW];

  always_ff @(posedge CLK) begin
    if (a_we) mem[a_idx] <= a_wdata;  // bus side
    if (b_we) mem[b_idx] <= b_wdata;  // channel side
    a_rdata <= mem[a_idx];
    b_rdata <= mem[b_idx];
  end

  // bus window and channel must not collide on one word
  a_no_dual_write: assert property (@(posedge CLK)
    !(a_we && b_we && (a_idx == b_idx)));

endmodule

/* src/tcdm_channel.sv */
//####################
// block transfer engine, one outstanding TCDM access
// cfg_wen 1 copies TCDM into the operand memory, 0 copies out
// launch is ignored while busy or with a zero length
//####################
`timescale 1ns/1ps
module tcdm_channel
  import fabric_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              launch,
  input  logic [ADDR_W-1:0] cfg_addr,
  input  logic [BE_W-1:0]   cfg_be,
  input  logic              cfg_wen,
  input  logic [LEN_W-1:0]  cfg_len,
  output logic              busy,
  output logic [DATA_W-1:0] result,
  output logic              tcdm_req,
  output logic              tcdm_wen,
  output logic [ADDR_W-1:0] tcdm_addr,
  output logic [DATA_W-1:0] tcdm_wdata,
  output logic [BE_W-1:0]   tcdm_be,
  input  logic              tcdm_gnt,
  input  logic              tcdm_valid,
  input  logic [DATA_W-1:0] tcdm_rdata,
  output logic [RAM_AW-1:0] ram_idx,
  output logic              ram_we,
  output logic [DATA_W-1:0] ram_wdata,
  input  logic [DATA_W-1:0] ram_rdata
);

  chan_state_e      state;
  logic [LEN_W-1:0] cnt;  // words completed
  logic [LEN_W-1:0] cnt_nxt;
  logic [LEN_W-1:0] len_q;
  logic             start;
  logic             beat_done;
  logic             last_beat;

  assign start     = (state == CH_IDLE) && launch && (cfg_len != '0);
  assign beat_done = (state == CH_WAIT) && tcdm_valid;
  assign cnt_nxt   = cnt + 1'b1;
  assign last_beat = (cnt_nxt == len_q);

  assign busy       = (state != CH_IDLE);
  assign ram_idx    = RAM_AW'(cnt);  // memory index follows the word count
  assign ram_we     = beat_done && tcdm_wen;  // store on the read beat itself
  assign ram_wdata  = tcdm_rdata;
  assign tcdm_wdata = ram_rdata;  // stable while the index is held

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CH_IDLE;
      cnt      <= '0;
      tcdm_req <= 1'b0;
      result   <= '0;
    end else begin
      case (state)
        CH_IDLE: begin
          if (start) begin
            cnt <= '0;
            if (cfg_wen) begin
              state    <= CH_REQ;
              tcdm_req <= 1'b1;
            end else begin
              state <= CH_FETCH;
            end
          end
        end
        CH_FETCH: begin  // memory latches the word this cycle
          state    <= CH_REQ;
          tcdm_req <= 1'b1;
        end
        CH_REQ: begin
          if (tcdm_gnt) begin
            tcdm_req <= 1'b0;
            state    <= CH_WAIT;
          end
        end
        CH_WAIT: begin
          if (tcdm_valid) begin
            cnt <= cnt_nxt;
            if (tcdm_wen) result <= tcdm_rdata;
            if (last_beat) begin
              state <= CH_IDLE;
            end else if (tcdm_wen) begin
              state    <= CH_REQ;
              tcdm_req <= 1'b1;
            end else begin
              state <= CH_FETCH;
            end
          end
        end
        default: state <= CH_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      tcdm_addr <= cfg_addr;
      tcdm_be   <= cfg_be;
      tcdm_wen  <= cfg_wen;
      len_q     <= cfg_len;
    end else if (beat_done) begin
      tcdm_addr <= tcdm_addr + ADDR_W'(4);  // next word
    end
  end

  a_no_req_idle: assert property (@(posedge CLK) disable iff (!rst_n)
    (state == CH_IDLE) |-> !tcdm_req);

endmodule

/* src/lint_slave.sv */
//####################
// register bus slave, one access at a time
// master must drop lint_req for a cycle between requests
// write: gnt in cycle 1, valid in cycle 2; read: gnt 3, valid 4
//####################
`timescale 1ns/1ps
module lint_slave
  import fabric_pkg::*;
#(
  parameter int NUM_CHAN = 2
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                lint_req,
  input  logic                lint_wen,
  input  logic [ADDR_W-1:0]   lint_addr,
  input  logic [DATA_W-1:0]   lint_wdata,
  input  logic [BE_W-1:0]     lint_be,
  output logic                lint_gnt,
  output logic                lint_valid,
  output logic [DATA_W-1:0]   lint_rdata,
  input  logic [DATA_W-1:0]   ram_rdata_aligned,
  input  logic [NUM_CHAN-1:0] chan_busy,
  input  logic [DATA_W-1:0]   chan_result [NUM_CHAN],
  output logic [NUM_CHAN-1:0] ram_sel,
  output logic [11:0]         ram_addr,
  output logic                ram_we,
  output logic [DATA_W-1:0]   ram_wdata_raw,
  output ram_mode_e [1:0]     ram_mode [NUM_CHAN],
  output logic [ADDR_W-1:0]   cfg_addr [NUM_CHAN],
  output logic [BE_W-1:0]     cfg_be [NUM_CHAN],
  output logic [NUM_CHAN-1:0] cfg_wen,
  output logic [LEN_W-1:0]    cfg_len [NUM_CHAN],
  output logic [NUM_CHAN-1:0] launch
);

  bus_state_e            state;
  logic                  saved_req;
  logic                  new_req;
  logic [DATA_W-1:0]     cfg_reg [NUM_CHAN];
  logic [4*NUM_CHAN-1:0] mode_reg;  // rmode in 4n+1..4n, wmode in 4n+3..4n+2
  logic [NUM_CHAN-1:0]   win_hit;
  logic [NUM_CHAN-1:0]   cfg_hit;
  logic [NUM_CHAN-1:0]   res_hit;
  logic [NUM_CHAN-1:0]   launch_hit;
  logic [DATA_W-1:0]     reg_rdata;

  assign new_req = lint_req & ~saved_req & ~lint_gnt;  // rising request edge

  always_comb begin
    win_hit    = '0;
    cfg_hit    = '0;
    res_hit    = '0;
    launch_hit = '0;
    for (int n = 0; n < NUM_CHAN; n++) begin
      win_hit[n]    = (lint_addr[ADDR_W-1:12] == RAM_REGION_BASE + 8'(n));
      cfg_hit[n]    = (lint_addr == OFS_CFG + ADDR_W'(4 * n));
      res_hit[n]    = (lint_addr == OFS_RESULT + ADDR_W'(4 * n));
      launch_hit[n] = (lint_addr == OFS_LAUNCH + ADDR_W'(4 * n));
    end
  end

  // register read mux, zero when nothing matches
  always_comb begin
    reg_rdata = '0;
    for (int n = 0; n < NUM_CHAN; n++) begin
      if (cfg_hit[n]) reg_rdata = cfg_reg[n];
      if (res_hit[n]) reg_rdata = chan_result[n];
    end
    if (lint_addr == OFS_RAM_MODE) reg_rdata = DATA_W'(mode_reg);
    if (lint_addr == OFS_STATUS) reg_rdata = DATA_W'(chan_busy);
    if (lint_addr == OFS_ID) reg_rdata = ID_WORD;
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state      <= BUS_IDLE;
      saved_req  <= 1'b0;
      lint_gnt   <= 1'b0;
      lint_valid <= 1'b0;
      ram_sel    <= '0;
      ram_we     <= 1'b0;
      launch     <= '0;
      mode_reg   <= '0;
      for (int n = 0; n < NUM_CHAN; n++) cfg_reg[n] <= '0;
    end else begin
      saved_req  <= lint_req;
      lint_gnt   <= 1'b0;
      lint_valid <= lint_gnt;  // valid always trails gnt by a cycle
      ram_we     <= 1'b0;
      launch     <= '0;
      case (state)
        BUS_IDLE: begin
          if (new_req) begin
            ram_sel <= win_hit;  // held for the whole access
            if (!lint_wen) begin
              lint_gnt <= 1'b1;
              state    <= BUS_WRITE;
            end else begin
              state <= BUS_READ;
            end
          end
        end
        BUS_WRITE: begin
          state  <= BUS_IDLE;
          ram_we <= |ram_sel;
          launch <= launch_hit;
          if (lint_addr == OFS_RAM_MODE) mode_reg <= lint_wdata[4*NUM_CHAN-1:0];
          for (int n = 0; n < NUM_CHAN; n++) begin
            for (int b = 0; b < BE_W; b++) begin
              if (cfg_hit[n] && lint_be[b]) cfg_reg[n][8*b +: 8] <= lint_wdata[8*b +: 8];
            end
          end
        end
        BUS_READ: state <= BUS_READ_WAIT;
        BUS_READ_WAIT: begin
          lint_gnt <= 1'b1;
          state    <= BUS_IDLE;
        end
        default: state <= BUS_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == BUS_IDLE && new_req) ram_addr <= lint_addr[11:0];
    if (state == BUS_WRITE) ram_wdata_raw <= lint_wdata;
    if (state == BUS_READ) lint_rdata <= reg_rdata;
    if (state == BUS_READ_WAIT && |ram_sel) lint_rdata <= ram_rdata_aligned;  // memory word
  end

  for (genvar n = 0; n < NUM_CHAN; n++) begin : g_cfg
    assign cfg_addr[n]    = cfg_reg[n][ADDR_W-1:0];
    assign cfg_be[n]      = cfg_reg[n][23:20];
    assign cfg_len[n]     = cfg_reg[n][30:24];
    assign cfg_wen[n]     = cfg_reg[n][31];  // 1 reads from TCDM
    assign ram_mode[n][0] = ram_mode_e'(mode_reg[4*n +: 2]);  // read mode
    assign ram_mode[n][1] = ram_mode_e'(mode_reg[4*n+2 +: 2]);  // write mode
  end

  // grant and valid are separate one-cycle pulses
  a_gnt_valid_excl: assert property (@(posedge CLK) disable iff (!rst_n)
    !(lint_gnt && lint_valid));

endmodule

/* src/fabric_top.sv */
//####################
// transfer fabric: bus slave, lane aligner, per-channel memory and engine
// RAM_AW at most 10, each memory window spans 4 KB of bus space
// NUM_CHAN from 1 to 4
//####################
`timescale 1ns/1ps
module fabric_top
  import fabric_pkg::*;
#(
  parameter int NUM_CHAN = 2,
  parameter int RAM_AW   = 10
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                lint_req,
  input  logic                lint_wen,
  input  logic [ADDR_W-1:0]   lint_addr,
  input  logic [DATA_W-1:0]   lint_wdata,
  input  logic [BE_W-1:0]     lint_be,
  output logic                lint_gnt,
  output logic                lint_valid,
  output logic [DATA_W-1:0]   lint_rdata,
  output logic [NUM_CHAN-1:0] tcdm_req,
  output logic [NUM_CHAN-1:0] tcdm_wen,
  output logic [ADDR_W-1:0]   tcdm_addr [NUM_CHAN],
  output logic [DATA_W-1:0]   tcdm_wdata [NUM_CHAN],
  output logic [BE_W-1:0]     tcdm_be [NUM_CHAN],
  input  logic [NUM_CHAN-1:0] tcdm_gnt,
  input  logic [NUM_CHAN-1:0] tcdm_valid,
  input  logic [DATA_W-1:0]   tcdm_rdata [NUM_CHAN]
);

  logic [NUM_CHAN-1:0] ram_sel;
  logic [11:0]         ram_addr;
  logic                ram_we;
  logic [DATA_W-1:0]   ram_wdata_raw;
  ram_mode_e [1:0]     ram_mode [NUM_CHAN];
  ram_mode_e           sel_rmode;
  ram_mode_e           sel_wmode;
  logic [DATA_W-1:0]   sel_rdata;
  logic [DATA_W-1:0]   wdata_word;
  logic [DATA_W-1:0]   rdata_aligned;
  logic [DATA_W-1:0]   a_rdata [NUM_CHAN];
  logic [ADDR_W-1:0]   cfg_addr [NUM_CHAN];
  logic [BE_W-1:0]     cfg_be [NUM_CHAN];
  logic [NUM_CHAN-1:0] cfg_wen;
  logic [LEN_W-1:0]    cfg_len [NUM_CHAN];
  logic [NUM_CHAN-1:0] launch;
  logic [NUM_CHAN-1:0] chan_busy;
  logic [DATA_W-1:0]   chan_result [NUM_CHAN];
  logic [RAM_AW-1:0]   b_idx [NUM_CHAN];
  logic [NUM_CHAN-1:0] b_we;
  logic [DATA_W-1:0]   b_wdata [NUM_CHAN];
  logic [DATA_W-1:0]   b_rdata [NUM_CHAN];

  lint_slave #(.NUM_CHAN(NUM_CHAN)) u_slave (
    .CLK, .rst_n, .lint_req, .lint_wen, .lint_addr, .lint_wdata, .lint_be,
    .lint_gnt, .lint_valid, .lint_rdata,
    .ram_rdata_aligned(rdata_aligned), .chan_busy, .chan_result,
    .ram_sel, .ram_addr, .ram_we, .ram_wdata_raw, .ram_mode,
    .cfg_addr, .cfg_be, .cfg_wen, .cfg_len, .launch
  );

  // ram_sel is one-hot, so the bus side sees only the addressed memory
  always_comb begin
    sel_rmode = MODE_WORD;
    sel_wmode = MODE_WORD;
    sel_rdata = '0;
    for (int n = 0; n < NUM_CHAN; n++) begin
      if (ram_sel[n]) begin
        sel_rmode = ram_mode[n][0];
        sel_wmode = ram_mode[n][1];
        sel_rdata = a_rdata[n];
      end
    end
  end

  lane_align u_align (
    .addr_lo(ram_addr[1:0]), .wmode(sel_wmode), .rmode(sel_rmode),
    .wdata_raw(ram_wdata_raw), .rdata_word(sel_rdata),
    .wdata_word, .rdata_aligned
  );

  for (genvar n = 0; n < NUM_CHAN; n++) begin : g_chan
    operand_ram #(.RAM_AW(RAM_AW)) u_ram (
      .CLK,
      .a_idx(ram_addr[RAM_AW+1:2]), .a_we(ram_we & ram_sel[n]),
      .a_wdata(wdata_word), .a_rdata(a_rdata[n]),
      .b_idx(b_idx[n]), .b_we(b_we[n]), .b_wdata(b_wdata[n]), .b_rdata(b_rdata[n])
    );

    tcdm_channel #(.RAM_AW(RAM_AW)) u_chan (
      .CLK, .rst_n, .launch(launch[n]),
      .cfg_addr(cfg_addr[n]), .cfg_be(cfg_be[n]), .cfg_wen(cfg_wen[n]),
      .cfg_len(cfg_len[n]), .busy(chan_busy[n]), .result(chan_result[n]),
      .tcdm_req(tcdm_req[n]), .tcdm_wen(tcdm_wen[n]), .tcdm_addr(tcdm_addr[n]),
      .tcdm_wdata(tcdm_wdata[n]), .tcdm_be(tcdm_be[n]),
      .tcdm_gnt(tcdm_gnt[n]), .tcdm_valid(tcdm_valid[n]), .tcdm_rdata(tcdm_rdata[n]),
      .ram_idx(b_idx[n]), .ram_we(b_we[n]), .ram_wdata(b_wdata[n]),
      .ram_rdata(b_rdata[n])
    );
  end

endmodule

/* verif/tcdm_model.sv */
//####################
// behavioral TCDM slave for one channel port
// grants on about half the cycles, valid and read data one cycle later
// 256 words aliased on addr[9:2], writes honour byte enables
//####################
`timescale 1ns/1ps
module tcdm_model
  import fabric_pkg::*;
#(
  parameter int DEPTH = 256
) (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              req,
  input  logic              wen,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  input  logic [BE_W-1:0]   be,
  output logic              gnt,
  output logic              valid,
  output logic [DATA_W-1:0] rdata
);

  localparam int IW = $clog2(DEPTH);

  logic [DATA_W-1:0] mem [DEPTH];  // preloaded and inspected from the testbench
  logic              grant_ok;
  logic [31:0]       rnd;
  logic [IW-1:0]     idx;
  integer            seed;
  int                n_gnt;  // accepted accesses since reset

  initial seed = 19;

  assign idx = addr[IW+1:2];
  assign gnt = req & grant_ok;  // stall when the coin says no

  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      grant_ok <= 1'b0;
      valid    <= 1'b0;
      rdata    <= '0;
      n_gnt    <= 0;
    end else begin
      rnd = $random(seed);
      grant_ok <= rnd[0];
      valid    <= gnt;
      if (gnt) begin
        n_gnt <= n_gnt + 1;
        if (wen) begin
          rdata <= mem[idx];
        end else begin
          for (int b = 0; b < BE_W; b++) begin
            if (be[b]) mem[idx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

/* verif/tb_fabric.sv */
//####################
// testbench for fabric_top with two channels, one TCDM model each
// walks a stimulus table over the register bus, one access at a time
// model memories are preloaded and inspected through the hierarchy
//####################
`timescale 1ns/1ps
module tb_fabric
  import fabric_pkg::*;
();

  localparam int NUM_CHAN   = 2;
  localparam int RAM_AW     = 10;
  localparam int XFER_WORDS = 11;  // 6 in on channel 0, 5 out on channel 1
  localparam int BUS_MAX    = 12;  // cycles allowed for one bus access
  localparam int POLL_MAX   = 100;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_WAIT, OP_MEM, OP_CNT} op_e;

  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] exp_data;
  } step_t;

  logic                CLK;
  logic                rst_n;
  logic                lint_req;
  logic                lint_wen;
  logic [ADDR_W-1:0]   lint_addr;
  logic [DATA_W-1:0]   lint_wdata;
  logic [BE_W-1:0]     lint_be;
  wire                 lint_gnt;
  wire                 lint_valid;
  wire  [DATA_W-1:0]   lint_rdata;
  wire  [NUM_CHAN-1:0] tcdm_req;
  wire  [NUM_CHAN-1:0] tcdm_wen;
  wire  [ADDR_W-1:0]   tcdm_addr [NUM_CHAN];
  wire  [DATA_W-1:0]   tcdm_wdata [NUM_CHAN];
  wire  [BE_W-1:0]     tcdm_be [NUM_CHAN];
  wire  [NUM_CHAN-1:0] tcdm_gnt;
  wire  [NUM_CHAN-1:0] tcdm_valid;
  wire  [DATA_W-1:0]   tcdm_rdata [NUM_CHAN];

  step_t steps[$];
  int    errors;
  int    checks;
  int    cycles;
  int    cycle_limit;

  fabric_top #(.NUM_CHAN(NUM_CHAN), .RAM_AW(RAM_AW)) UUT (
    .CLK, .rst_n, .lint_req, .lint_wen, .lint_addr, .lint_wdata, .lint_be,
    .lint_gnt, .lint_valid, .lint_rdata,
    .tcdm_req, .tcdm_wen, .tcdm_addr, .tcdm_wdata, .tcdm_be,
    .tcdm_gnt, .tcdm_valid, .tcdm_rdata
  );

  tcdm_model u_tcdm0 (
    .CLK, .rst_n, .req(tcdm_req[0]), .wen(tcdm_wen[0]), .addr(tcdm_addr[0]),
    .wdata(tcdm_wdata[0]), .be(tcdm_be[0]), .gnt(tcdm_gnt[0]),
    .valid(tcdm_valid[0]), .rdata(tcdm_rdata[0])
  );

  tcdm_model u_tcdm1 (
    .CLK, .rst_n, .req(tcdm_req[1]), .wen(tcdm_wen[1]), .addr(tcdm_addr[1]),
    .wdata(tcdm_wdata[1]), .be(tcdm_be[1]), .gnt(tcdm_gnt[1]),
    .valid(tcdm_valid[1]), .rdata(tcdm_rdata[1])
  );

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout, run went past %0d cycles", cycle_limit);
      $display("%0d checks, %0d errors", checks, errors);
      $display("** FAIL **");
      $finish;
    end
  end

  // model word as a function of the whole word index
  function automatic logic [DATA_W-1:0] fill_word(input int ch, input int idx);
    logic [7:0] i;
    i = idx[7:0];
    return {4'hC, ch[3:0], i, ~i, i ^ 8'h5A};
  endfunction

  // lane kept after a narrow write and read at one byte address
  function automatic logic [DATA_W-1:0] lane_mask(input int mode, input int lo);
    case (ram_mode_e'(mode))
      MODE_HALF: return 32'h0000FFFF << (16 * (lo / 2));
      MODE_BYTE: return 32'h000000FF << (8 * lo);
      default:   return 32'hFFFFFFFF;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [DATA_W-1:0] exp_val,
                             input logic [DATA_W-1:0] got);
    checks++;
    assert (got === exp_val) else begin
      $display("Fail %s: expected %h, got %h", what, exp_val, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // entered 1 ns after a rising edge, returns 1 ns after one
  task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                            output logic [DATA_W-1:0] rdata, output int gnt_cyc,
                            output int valid_cyc);
    int cyc;
    cyc       = 0;
    gnt_cyc   = 0;
    valid_cyc = 0;
    rdata     = '0;
    lint_req   = 1'b1;
    lint_wen   = ~wr;  // 0 writes
    lint_addr  = addr;
    lint_wdata = wdata;
    lint_be    = be;
    while (valid_cyc == 0 && cyc < BUS_MAX) begin
      @(posedge CLK);
      cyc++;
      @(negedge CLK);  // mid cycle, outputs settled
      if (lint_gnt && gnt_cyc == 0) gnt_cyc = cyc;
      if (lint_valid) begin
        valid_cyc = cyc;
        rdata     = lint_rdata;
      end
    end
    check_true(valid_cyc != 0, $sformatf("no lint_valid for access to %h", addr));
    @(posedge CLK);
    #1;
    lint_req = 1'b0;
    @(posedge CLK);  // request low for one sampled edge
    #1;
  endtask

  task automatic add_step(input op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                          input logic [DATA_W-1:0] exp_data);
    step_t s;
    s.op       = op;
    s.addr     = addr;
    s.wdata    = wdata;
    s.be       = be;
    s.exp_data = exp_data;
    steps.push_back(s);
  endtask

  task automatic build_table();
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic [DATA_W-1:0] src;
    // register access, partial configuration write
    add_step(OP_WR, OFS_CFG + 4, 32'h11223344, 4'hF, '0);
    add_step(OP_WR, OFS_CFG + 4, 32'hAABBCCDD, 4'b0101, '0);
    add_step(OP_RD, OFS_CFG + 4, '0, 4'hF, 32'h11BB33DD);
    add_step(OP_RD, OFS_ID, '0, 4'hF, ID_WORD);
    add_step(OP_RD, 20'h00300, '0, 4'hF, '0);  // unmapped
    // lane modes on memory 0, fresh word for every case
    for (int m = 0; m < 4; m++) begin
      add_step(OP_WR, OFS_RAM_MODE, 32'(m * 5), 4'hF, '0);  // same read and write mode
      for (int lo = 0; lo < 4; lo++) begin
        a = 20'h01000 + ADDR_W'((m * 4 + lo + 8) * 4 + lo);
        d = 32'h8C4D19E7 ^ (32'(m * 4 + lo) * 32'h01030507);
        add_step(OP_WR, a, d, 4'hF, '0);
        add_step(OP_RD, a, '0, 4'hF, d & lane_mask(m, lo));
      end
    end
    add_step(OP_WR, OFS_RAM_MODE, '0, 4'hF, '0);
    // channel 0 reads 6 words from TCDM, second launch lands while busy
    add_step(OP_WR, OFS_CFG, {1'b1, 7'd6, 4'hF, 20'h04040}, 4'hF, '0);
    add_step(OP_WR, OFS_LAUNCH, 32'd1, 4'hF, '0);
    add_step(OP_WR, OFS_LAUNCH, 32'd1, 4'hF, '0);
    add_step(OP_RD, OFS_STATUS, '0, 4'hF, 32'd1);
    add_step(OP_WAIT, OFS_STATUS, 32'd1, 4'hF, '0);
    for (int i = 0; i < 6; i++) begin
      add_step(OP_RD, 20'h01000 + ADDR_W'(4 * i), '0, 4'hF, fill_word(0, 16 + i));
    end
    add_step(OP_RD, OFS_RESULT, '0, 4'hF, fill_word(0, 21));
    add_step(OP_CNT, '0, 32'd0, 4'hF, 32'd6);
    // channel 1 writes 5 words out with byte enables 1011
    for (int i = 0; i < 5; i++) begin
      src = 32'h3C5A0F00 + 32'(i) * 32'h01110111;
      add_step(OP_WR, 20'h02000 + ADDR_W'(4 * i), src, 4'hF, '0);
    end
    add_step(OP_WR, OFS_CFG + 4, {1'b0, 7'd5, 4'hB, 20'h08040}, 4'hF, '0);
    add_step(OP_WR, OFS_LAUNCH + 4, 32'd1, 4'hF, '0);
    add_step(OP_WAIT, OFS_STATUS, 32'd2, 4'hF, '0);
    for (int i = 0; i < 6; i++) begin
      src = 32'h3C5A0F00 + 32'(i) * 32'h01110111;
      d   = (i < 5) ? ((src & 32'hFF00FFFF) | (fill_word(1, 16 + i) & 32'h00FF0000))
                    : fill_word(1, 16 + i);  // word past the block untouched
      add_step(OP_MEM, 20'h08040 + ADDR_W'(4 * i), 32'd1, 4'hF, d);
    end
    add_step(OP_CNT, '0, 32'd1, 4'hF, 32'd5);
  endtask

  task automatic run_step(input step_t s);
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] got;
    int                gnt_cyc;
    int                valid_cyc;
    int                polls;
    case (s.op)
      OP_WR: begin
        bus_access(1'b1, s.addr, s.wdata, s.be, rdata, gnt_cyc, valid_cyc);
        check_value("lint_gnt cycle", 32'd1, 32'(gnt_cyc));
        check_value("lint_valid cycle", 32'd2, 32'(valid_cyc));
      end
      OP_RD: begin
        bus_access(1'b0, s.addr, '0, s.be, rdata, gnt_cyc, valid_cyc);
        check_value("lint_gnt cycle", 32'd3, 32'(gnt_cyc));
        check_value("lint_valid cycle", 32'd4, 32'(valid_cyc));
        check_value($sformatf("lint_rdata at %h", s.addr), s.exp_data, rdata);
      end
      OP_WAIT: begin  // poll status until the masked busy bits clear
        polls = 0;
        rdata = s.wdata;
        while ((rdata & s.wdata) != 0 && polls < POLL_MAX) begin
          bus_access(1'b0, OFS_STATUS, '0, s.be, rdata, gnt_cyc, valid_cyc);
          polls++;
        end
        check_true((rdata & s.wdata) == 0, "channel still busy after status polling");
      end
      OP_MEM: begin
        got = s.wdata[0] ? u_tcdm1.mem[s.addr[9:2]] : u_tcdm0.mem[s.addr[9:2]];
        check_value($sformatf("tcdm%0d mem at %h", s.wdata[0], s.addr), s.exp_data, got);
      end
      OP_CNT: begin
        got = s.wdata[0] ? u_tcdm1.n_gnt : u_tcdm0.n_gnt;
        check_value($sformatf("tcdm%0d grant count", s.wdata[0]), s.exp_data, got);
      end
      default: check_true(1'b0, "unknown operation in the stimulus table");
    endcase
  endtask

  initial begin
    CLK        = 1'b0;
    rst_n      = 1'b1;
    lint_req   = 1'b0;
    lint_wen   = 1'b1;
    lint_addr  = '0;
    lint_wdata = '0;
    lint_be    = '0;
    errors     = 0;
    checks     = 0;
    for (int i = 0; i < 256; i++) begin
      u_tcdm0.mem[i] = fill_word(0, i);
      u_tcdm1.mem[i] = fill_word(1, i);
    end
    build_table();
    cycle_limit = 20 * (steps.size() + XFER_WORDS);
    #1;
    rst_n = 1'b0;  // falling edge reaches the async resets
    repeat (5) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    @(posedge CLK);
    #1;
    foreach (steps[i]) run_step(steps[i]);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("** PASS **");
    else $display("** FAIL **");
    $finish;
  end

endmodule

/* sim.f */
src/fabric_pkg.sv
src/lane_align.sv
src/operand_ram.sv
src/tcdm_channel.sv
src/lint_slave.sv
src/fabric_top.sv
verif/tcdm_model.sv
verif/tb_fabric.sv

/* Bender.yml */
package:
  name: transfer_fabric

sources:
  - src/fabric_pkg.sv
  - src/lane_align.sv
  - src/operand_ram.sv
  - src/tcdm_channel.sv
  - src/lint_slave.sv
  - src/fabric_top.sv
  - target: simulation
    files:
      - verif/tcdm_model.sv
      - verif/tb_fabric.sv
